//--- vlog.f
+incdir+verilog
verilog/blur_pkg.sv
verilog/strip_ctrl.sv
verilog/line_buffer.sv
verilog/gauss_3x3_strip.sv
verilog/row_merge.sv
verilog/gauss_blur_top.sv
dv/tb_gauss_blur.sv

//--- dv/tb_gauss_blur.sv
`include "blur_defines.svh"

module tb_gauss_blur;
  timeunit 1ns;
  timeprecision 1ps;

  import blur_pkg::*;

  localparam int STRIP_BITS = `BLUR_STRIP_PIX * `BLUR_PIX_W;
  localparam int FRAME_WRITES = `BLUR_STRIPS * `BLUR_ROWS;

  logic      clk;
  logic      rst_n;
  logic      start;
  logic      done;
  mem_rd_t   img_req;
  row_word_t img_row;
  mem_rd_t   blur_req;
  row_word_t blur_dout;
  blur_wr_t  blur_wr;

  row_word_t   img_mem [`BLUR_ROWS];
  row_word_t   blur_mem [`BLUR_ROWS];
  logic [31:0] lfsr;
  int          errors;
  int          total_wr;
  int          frame_wr;
  bit          hung;
  string       test_name;

  gauss_blur_top u_gauss_blur_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .done      (done),
    .img_req   (img_req),
    .img_row   (img_row),
    .blur_req  (blur_req),
    .blur_dout (blur_dout),
    .blur_wr   (blur_wr)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // galois lfsr, one step per bit
  function automatic logic rand_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b)
      lfsr = lfsr ^ 32'h80200003;
    return b;
  endfunction

  function automatic row_word_t rand_word();
    row_word_t w;
    for (int i = 0; i < $bits(row_word_t); i++)
      w[i] = rand_bit();
    return w;
  endfunction

  function automatic int img_pix(input int r, input int c);
    if (r < 0 || r >= `BLUR_ROWS || c < 0 || c >= `BLUR_ROW_PIX)
      return 0;
    return int'(img_mem[r][c*`BLUR_PIX_W +: `BLUR_PIX_W]);
  endfunction

  // expected blur of strip s in row r, then merged into the old word
  function automatic row_word_t expected_word(input int s, input int r, input row_word_t old);
    strip_t    res;
    row_word_t keep;
    int        acc;
    int        w;
    for (int i = 0; i < `BLUR_STRIP_PIX; i++) begin
      acc = 0;
      for (int dy = -1; dy <= 1; dy++) begin
        for (int dx = -1; dx <= 1; dx++) begin
          w = ((dy == 0) ? 2 : 1) * ((dx == 0) ? 2 : 1);
          acc += w * img_pix(r + dy, s * `BLUR_STRIP_PIX + i + dx);
        end
      end
      res[i*`BLUR_PIX_W +: `BLUR_PIX_W] = acc / 16;
    end
    keep = (row_word_t'(1) << (s * STRIP_BITS)) - 1'b1;
    return (old & keep) | (row_word_t'(res) << (s * STRIP_BITS));
  endfunction

  // image and blur memories, one cycle read latency
  always begin
    mem_rd_t  img_q;
    mem_rd_t  blur_q;
    blur_wr_t wr_q;
    @(posedge clk);
    img_q  = img_req;
    blur_q = blur_req;
    wr_q   = blur_wr;
    #2;
    if (img_q.rd)
      img_row = img_mem[img_q.addr];
    if (blur_q.rd)
      blur_dout = blur_mem[blur_q.addr];
    if (wr_q.we)
      blur_mem[wr_q.addr] = wr_q.data;
  end

  // compare every write in the middle of its cycle
  always @(negedge clk) begin
    int        s;
    int        r;
    row_word_t exp_word;
    if (rst_n && blur_wr.we) begin
      s = frame_wr / `BLUR_ROWS;
      r = frame_wr % `BLUR_ROWS;
      if (frame_wr >= FRAME_WRITES) begin
        errors++;
        $display("Error %s: more than %0d writes in one frame", test_name, FRAME_WRITES);
      end else begin
        if (blur_wr.addr !== row_addr_t'(r)) begin
          errors++;
          $display("Error %s: write address expected %0d actual %0d",
                   test_name, r, blur_wr.addr);
        end
        exp_word = expected_word(s, r, blur_mem[r]);
        if (blur_wr.data !== exp_word) begin
          errors++;
          $display("Error %s: strip %0d row %0d data expected %h actual %h",
                   test_name, s, r, exp_word, blur_wr.data);
        end
      end
      frame_wr++;
      total_wr++;
    end
  end

  task automatic finish_run();
    $display("errors: %0d, writes checked: %0d", errors, total_wr);
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  endtask

  task automatic check_value(input string what, input int expected, input int actual);
    if (expected != actual) begin
      errors++;
      $display("Error %s: %s expected %0d actual %0d", test_name, what, expected, actual);
    end
  endtask

  task automatic run_frame(input bit hold_start);
    int n;
    frame_wr = 0;
    @(posedge clk);
    #2 start = 1'b1;
    @(posedge clk);
    #2;
    if (!hold_start)
      start = 1'b0;
    n = 0;
    while (!done && n < 2000) begin
      @(negedge clk);
      n++;
    end
    if (!done) begin
      errors++;
      hung = 1'b1;
      $display("timeout: done did not rise within 2000 cycles in %s", test_name);
    end else begin
      check_value("writes when done rose", FRAME_WRITES, frame_wr);
      @(posedge clk);
      #2 start = 1'b0;
      // no restart and done held while idle
      repeat (10) @(posedge clk);
      @(negedge clk);
      check_value("done after frame", 1, int'(done));
      check_value("writes per frame", FRAME_WRITES, frame_wr);
    end
  endtask

  task automatic run_tests();
    test_name = "random_frame";
    for (int r = 0; r < `BLUR_ROWS; r++) begin
      img_mem[r]  = rand_word();
      blur_mem[r] = rand_word();
    end
    run_frame(1'b0);
    if (hung)
      return;

    // flat image shows the zero fill on every edge
    test_name = "flat_frame";
    for (int r = 0; r < `BLUR_ROWS; r++)
      img_mem[r] = '1;
    run_frame(1'b0);
    if (hung)
      return;
    check_value("corner pixel", 143, int'(blur_mem[0][7:0]));
    check_value("far corner pixel", 143, int'(blur_mem[15][31*`BLUR_PIX_W +: `BLUR_PIX_W]));
    check_value("top edge pixel", 191, int'(blur_mem[0][5*`BLUR_PIX_W +: `BLUR_PIX_W]));
    check_value("left edge pixel", 191, int'(blur_mem[7][7:0]));
    check_value("interior pixel", 255, int'(blur_mem[7][12*`BLUR_PIX_W +: `BLUR_PIX_W]));

    test_name = "second_start";
    for (int r = 0; r < `BLUR_ROWS; r++)
      img_mem[r] = rand_word();
    run_frame(1'b0);
    if (hung)
      return;

    test_name = "held_start";
    for (int r = 0; r < `BLUR_ROWS; r++)
      img_mem[r] = rand_word();
    run_frame(1'b1);
  endtask

  initial begin
    rst_n     = 1'b0;
    start     = 1'b0;
    img_row   = '0;
    blur_dout = '0;
    errors    = 0;
    total_wr  = 0;
    frame_wr  = 0;
    hung      = 1'b0;
    lfsr      = 32'hdc01291c;
    test_name = "reset";
    repeat (2) @(posedge clk);
    #2 rst_n = 1'b1;
    @(negedge clk);
    check_value("done", 0, int'(done));
    check_value("img_req.rd", 0, int'(img_req.rd));
    check_value("blur_req.rd", 0, int'(blur_req.rd));
    check_value("blur_wr.we", 0, int'(blur_wr.we));

    run_tests();
    finish_run();
  end

endmodule

//--- verilog/gauss_blur_top.sv
module gauss_blur_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start,
  output logic                done,
  output blur_pkg::mem_rd_t   img_req,
  input  blur_pkg::row_word_t img_row,
  output blur_pkg::mem_rd_t   blur_req,
  input  blur_pkg::row_word_t blur_dout,
  output blur_pkg::blur_wr_t  blur_wr
);
  import blur_pkg::*;

  strip_idx_t strip;
  logic       clear;
  logic       shift;
  logic       fill_zero;
  logic       wr_we;
  row_addr_t  wr_addr;
  window_t    window;
  strip_t     filtered;
  row_word_t  merged;

  strip_ctrl u_strip_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .done      (done),
    .img_req   (img_req),
    .blur_req  (blur_req),
    .wr_we     (wr_we),
    .wr_addr   (wr_addr),
    .strip     (strip),
    .clear     (clear),
    .shift     (shift),
    .fill_zero (fill_zero)
  );

  line_buffer u_line_buffer (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear     (clear),
    .shift     (shift),
    .fill_zero (fill_zero),
    .strip     (strip),
    .img_row   (img_row),
    .window    (window)
  );

  gauss_3x3_strip u_gauss_3x3_strip (
    .clk      (clk),
    .rst_n    (rst_n),
    .window   (window),
    .filtered (filtered)
  );

  row_merge u_row_merge (
    .clk       (clk),
    .rst_n     (rst_n),
    .strip     (strip),
    .filtered  (filtered),
    .blur_dout (blur_dout),
    .merged    (merged)
  );

  assign blur_wr = '{we: wr_we, addr: wr_addr, data: merged};

endmodule

//--- verilog/row_merge.sv
`include "blur_defines.svh"

module row_merge (
  input  logic                 clk,
  input  logic                 rst_n,
  input  blur_pkg::strip_idx_t strip,
  input  blur_pkg::strip_t     filtered,
  input  blur_pkg::row_word_t  blur_dout,
  output blur_pkg::row_word_t  merged
);
  import blur_pkg::*;

  localparam int STRIP_BITS = `BLUR_STRIP_PIX * `BLUR_PIX_W;

  row_word_t merged_nxt;

  // earlier strips kept, current strip replaced, later strips zero
  always_comb begin
    merged_nxt = '0;
    for (int s = 0; s < `BLUR_STRIPS; s++) begin
      if (s < int'(strip))
        merged_nxt[s*STRIP_BITS +: STRIP_BITS] = blur_dout[s*STRIP_BITS +: STRIP_BITS];
      else if (s == int'(strip))
        merged_nxt[s*STRIP_BITS +: STRIP_BITS] = filtered;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n)
      merged <= '0;
    else
      merged <= merged_nxt;
  end

endmodule

//--- verilog/gauss_3x3_strip.sv
`include "blur_defines.svh"

module gauss_3x3_strip (
  input  logic              clk,
  input  logic              rst_n,
  input  blur_pkg::window_t window,
  output blur_pkg::strip_t  filtered
);
  import blur_pkg::*;

  strip_t filt_nxt;

  function automatic pixel_t pix(input halo_row_t h, input int j);
    return h[j*`BLUR_PIX_W +: `BLUR_PIX_W];
  endfunction

  // horizontal 1 2 1 over halo pixels i..i+2
  function automatic logic [`BLUR_PIX_W+1:0] tap3(input halo_row_t h, input int i);
    logic [`BLUR_PIX_W+1:0] a;
    logic [`BLUR_PIX_W+1:0] b;
    logic [`BLUR_PIX_W+1:0] c;
    a = (`BLUR_PIX_W+2)'(pix(h, i));
    b = (`BLUR_PIX_W+2)'(pix(h, i + 1));
    c = (`BLUR_PIX_W+2)'(pix(h, i + 2));
    return a + (b << 1) + c;
  endfunction

  always_comb begin
    logic [`BLUR_PIX_W+3:0] acc;
    filt_nxt = '0;
    for (int i = 0; i < `BLUR_STRIP_PIX; i++) begin
      // vertical 1 2 1, total weight 16
      acc = (`BLUR_PIX_W+4)'(tap3(window.top, i))
          + ((`BLUR_PIX_W+4)'(tap3(window.mid, i)) << 1)
          + (`BLUR_PIX_W+4)'(tap3(window.bot, i));
      filt_nxt[i*`BLUR_PIX_W +: `BLUR_PIX_W] = acc[`BLUR_PIX_W+3:4];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n)
      filtered <= '0;
    else
      filtered <= filt_nxt;
  end

endmodule

//--- verilog/line_buffer.sv
`include "blur_defines.svh"

module line_buffer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 clear,
  input  logic                 shift,
  input  logic                 fill_zero,
  input  blur_pkg::strip_idx_t strip,
  input  blur_pkg::row_word_t  img_row,
  output blur_pkg::window_t    window
);
  import blur_pkg::*;

  halo_row_t halo;

  // cut strip plus halo, zero outside the image
  always_comb begin
    int col;
    halo = '0;
    for (int j = 0; j < `BLUR_STRIP_PIX + 2; j++) begin
      col = int'(strip) * `BLUR_STRIP_PIX + j - 1;
      if (!fill_zero && col >= 0 && col < `BLUR_ROW_PIX)
        halo[j*`BLUR_PIX_W +: `BLUR_PIX_W] = img_row[col*`BLUR_PIX_W +: `BLUR_PIX_W];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      window <= '0;
    end else if (shift) begin
      window.bot <= window.mid;
      window.mid <= window.top;
      window.top <= halo;
    end
  end

endmodule

//--- verilog/strip_ctrl.sv
`include "blur_defines.svh"

module strip_ctrl (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  output logic                 done,
  output blur_pkg::mem_rd_t    img_req,
  output blur_pkg::mem_rd_t    blur_req,
  output logic                 wr_we,
  output blur_pkg::row_addr_t  wr_addr,
  output blur_pkg::strip_idx_t strip,
  output logic                 clear,
  output logic                 shift,
  output logic                 fill_zero
);
  import blur_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    STRIP_START,
    LOAD,
    SHIFT,
    BLUR,
    MERGE,
    WRITE,
    DONE
  } state_t;

  state_t state;
  state_t state_nxt;

  // row being loaded, runs one past the last image row
  logic [`BLUR_ADDR_W:0] row_cnt;
  row_addr_t             row_out;
  logic                  wr_adv;
  logic                  last_row;
  logic                  last_strip;

  assign last_row   = (row_cnt == `BLUR_ROWS);
  assign last_strip = (int'(strip) == `BLUR_STRIPS - 1);

  // output row trails the loaded row by one
  assign row_out = row_addr_t'(row_cnt - 1'b1);

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:        if (start) state_nxt = STRIP_START;
      STRIP_START: state_nxt = LOAD;
      LOAD:        state_nxt = SHIFT;
      // first row of a strip only primes the window
      SHIFT:       state_nxt = (row_cnt == '0) ? LOAD : BLUR;
      BLUR:        state_nxt = MERGE;
      MERGE:       state_nxt = WRITE;
      WRITE: begin
        if (wr_adv) begin
          if (!last_row)
            state_nxt = LOAD;
          else if (last_strip)
            state_nxt = DONE;
          else
            state_nxt = STRIP_START;
        end
      end
      DONE:        state_nxt = IDLE;
      default:     state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= IDLE;
      row_cnt <= '0;
      strip   <= '0;
      wr_adv  <= 1'b0;
      done    <= 1'b0;
    end else begin
      state <= state_nxt;
      case (state)
        IDLE: begin
          if (start) begin
            strip <= '0;
            done  <= 1'b0;
          end
        end
        STRIP_START: row_cnt <= '0;
        SHIFT: begin
          if (row_cnt == '0)
            row_cnt <= row_cnt + 1'b1;
        end
        WRITE: begin
          // first cycle writes, second cycle advances
          wr_adv <= ~wr_adv;
          if (wr_adv && !last_row)
            row_cnt <= row_cnt + 1'b1;
          if (wr_adv && last_row && !last_strip)
            strip <= strip + 1'b1;
          if (!wr_adv && last_row && last_strip)
            done <= 1'b1;
        end
        default: begin
        end
      endcase
    end
  end

  // no image read past the bottom edge
  assign img_req  = '{rd: (state == LOAD) && !last_row, addr: row_cnt[`BLUR_ADDR_W-1:0]};
  assign blur_req = '{rd: (state == BLUR), addr: row_out};

  assign wr_we     = (state == WRITE) && !wr_adv;
  assign wr_addr   = row_out;
  assign clear     = (state == STRIP_START);
  assign shift     = (state == SHIFT);
  assign fill_zero = last_row;

  // write strobe lasts a single cycle
  assert property (@(posedge clk) disable iff (!rst_n)
    wr_we |=> !wr_we);

  // strip index only moves as a new strip begins
  assert property (@(posedge clk) disable iff (!rst_n)
    $changed(strip) |-> (state == STRIP_START));

  // read-modify-write lands on the row that was read
  assert property (@(posedge clk) disable iff (!rst_n)
    blur_req.rd |-> ##2 (wr_we && wr_addr == $past(blur_req.addr, 2)));

endmodule

//--- verilog/blur_pkg.sv
`include "blur_defines.svh"

package blur_pkg;

  typedef logic [`BLUR_PIX_W-1:0] pixel_t;

  // pixel 0 sits in the low bits of a row word
  typedef logic [`BLUR_ROW_PIX*`BLUR_PIX_W-1:0] row_word_t;
  typedef logic [`BLUR_STRIP_PIX*`BLUR_PIX_W-1:0] strip_t;

  // strip plus one neighbour pixel on each side
  typedef logic [(`BLUR_STRIP_PIX+2)*`BLUR_PIX_W-1:0] halo_row_t;

  // top holds the newest row
  typedef struct packed {
    halo_row_t top;
    halo_row_t mid;
    halo_row_t bot;
  } window_t;

  typedef logic [`BLUR_ADDR_W-1:0] row_addr_t;
  typedef logic [`BLUR_STRIP_W-1:0] strip_idx_t;

  typedef struct packed {
    logic      rd;
    row_addr_t addr;
  } mem_rd_t;

  typedef struct packed {
    logic      we;
    row_addr_t addr;
    row_word_t data;
  } blur_wr_t;

endpackage

//--- verilog/blur_defines.svh
`ifndef BLUR_DEFINES_SVH
`define BLUR_DEFINES_SVH

// pixel depth in bits
`define BLUR_PIX_W 8

// strip geometry, one strip is filtered per row pass
`define BLUR_STRIP_PIX 8
`define BLUR_STRIPS 4

// full row width in pixels
`define BLUR_ROW_PIX (`BLUR_STRIP_PIX * `BLUR_STRIPS)

// frame height and index widths
`define BLUR_ROWS 16
`define BLUR_ADDR_W 4
`define BLUR_STRIP_W 2

`endif
